// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - design/issue_pkg.sv
  - design/pair_check.sv
  - design/register_read.sv
  - design/issue_csr.sv
  - design/issue_control.sv
  - design/issue_top.sv
  - target: simulation
    files:
      - sim/issue_tb.sv

// ==== design/issue_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_control (
  input  logic clock,
  input  logic reset,
  input  logic in_valid_0,
  input  issue_pkg::opcode_t in_op_0,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rd_0,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rs1_0,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rs2_0,
  input  logic [issue_pkg::rm_width-1:0] in_rm_0,
  input  issue_pkg::csr_addr_t in_csr_0,
  input  logic in_valid_1,
  input  issue_pkg::opcode_t in_op_1,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rd_1,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rs1_1,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rs2_1,
  input  logic [issue_pkg::rm_width-1:0] in_rm_1,
  input  issue_pkg::csr_addr_t in_csr_1,
  input  logic ex_load,
  input  logic [issue_pkg::reg_addr_width-1:0] ex_rd,
  input  logic ex_stall,
  input  logic flush,
  input  logic pair_ok,
  output logic [issue_pkg::reg_addr_width-1:0] raddr0,
  output logic [issue_pkg::reg_addr_width-1:0] raddr1,
  output logic [issue_pkg::reg_addr_width-1:0] raddr2,
  output logic [issue_pkg::reg_addr_width-1:0] raddr3,
  input  logic [issue_pkg::data_width-1:0] rdata0,
  input  logic [issue_pkg::data_width-1:0] rdata1,
  input  logic [issue_pkg::data_width-1:0] rdata2,
  input  logic [issue_pkg::data_width-1:0] rdata3,
  output issue_pkg::csr_addr_t csr_rd_addr,
  input  logic [issue_pkg::data_width-1:0] csr_rd_data,
  input  logic fp_enable,
  input  logic [issue_pkg::rm_width-1:0] frm,
  output logic csr_wr_en,
  output issue_pkg::csr_addr_t csr_wr_addr,
  output logic [issue_pkg::data_width-1:0] csr_wr_data,
  output logic [1:0] take_count,
  output logic stall,
  output logic out_valid_0,
  output issue_pkg::opcode_t out_op_0,
  output logic [issue_pkg::reg_addr_width-1:0] out_rd_0,
  output logic [issue_pkg::data_width-1:0] out_src1_0,
  output logic [issue_pkg::data_width-1:0] out_src2_0,
  output logic [issue_pkg::rm_width-1:0] out_rm_0,
  output logic out_valid_1,
  output issue_pkg::opcode_t out_op_1,
  output logic [issue_pkg::reg_addr_width-1:0] out_rd_1,
  output logic [issue_pkg::data_width-1:0] out_src1_1,
  output logic [issue_pkg::data_width-1:0] out_src2_1,
  output logic [issue_pkg::rm_width-1:0] out_rm_1
);

  logic hazard0;
  logic hazard1;
  logic serialize;
  logic csr_pending;

  function automatic issue_pkg::opcode_t gate_fp(issue_pkg::opcode_t op, logic enable);
    return (op == issue_pkg::op_fpu && !enable) ? issue_pkg::op_illegal : op;
  endfunction

  function automatic logic [issue_pkg::rm_width-1:0] pick_rm(
    logic [issue_pkg::rm_width-1:0] rm,
    logic [issue_pkg::rm_width-1:0] csr_rm
  );
    return (rm == issue_pkg::rm_dynamic) ? csr_rm : rm;
  endfunction

  assign raddr0 = in_rs1_0;
  assign raddr1 = in_rs2_0;
  assign raddr2 = in_rs1_1;
  assign raddr3 = in_rs2_1;
  assign csr_rd_addr = in_csr_0;

  // Load-use against the load in execute
  assign hazard0 = ex_load && ex_rd != '0 &&
                   issue_pkg::reads_reg(in_op_0, in_rs1_0, in_rs2_0, ex_rd);
  assign hazard1 = ex_load && ex_rd != '0 &&
                   issue_pkg::reads_reg(in_op_1, in_rs1_1, in_rs2_1, ex_rd);

  // CSR and FP ops wait until the previous CSR write has landed
  assign serialize = csr_pending &&
                     (issue_pkg::is_csr_op(in_op_0) || in_op_0 == issue_pkg::op_fpu);

  always_comb begin
    if (ex_stall || flush || hazard0 || serialize || !in_valid_0) begin
      take_count = 2'd0;
    end else if (in_valid_1 && pair_ok && !hazard1) begin
      take_count = 2'd2;
    end else begin
      take_count = 2'd1;
    end
  end

  assign stall = in_valid_0 && take_count == 2'd0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      out_valid_0 <= 1'b0;
      out_valid_1 <= 1'b0;
      csr_pending <= 1'b0;
    end else begin
      csr_pending <= take_count != 2'd0 && in_op_0 == issue_pkg::op_csr_write;
      if (flush) begin
        out_valid_0 <= 1'b0;
        out_valid_1 <= 1'b0;
      end else if (!ex_stall) begin
        out_valid_0 <= take_count != 2'd0;
        out_valid_1 <= take_count == 2'd2;
      end
    end
  end

  // Sources follow the opcode as presented, before the FP gate
  always_ff @(posedge clock) begin
    if (!ex_stall) begin
      out_op_0 <= gate_fp(in_op_0, fp_enable);
      out_rd_0 <= in_rd_0;
      out_rm_0 <= pick_rm(in_rm_0, frm);
      if (in_op_0 == issue_pkg::op_csr_read) begin
        out_src1_0 <= csr_rd_data;
      end else begin
        out_src1_0 <= issue_pkg::reads_rs1(in_op_0) ? rdata0 : '0;
      end
      out_src2_0 <= issue_pkg::reads_rs2(in_op_0) ? rdata1 : '0;
      csr_wr_addr <= in_csr_0;
      out_op_1 <= gate_fp(in_op_1, fp_enable);
      out_rd_1 <= in_rd_1;
      out_rm_1 <= pick_rm(in_rm_1, frm);
      out_src1_1 <= issue_pkg::reads_rs1(in_op_1) ? rdata2 : '0;
      out_src2_1 <= issue_pkg::reads_rs2(in_op_1) ? rdata3 : '0;
    end
  end

  // Issued csr_write commits in the cycle after issue
  assign csr_wr_en = csr_pending;
  assign csr_wr_data = out_src1_0;

  assert property (@(posedge clock) disable iff (!reset) out_valid_1 |-> out_valid_0);

  assert property (@(posedge clock) disable iff (!reset) take_count != 2'd3);

  // Slot 1 CSR index is consumed later, once the op moves up to slot 0
  assert property (@(posedge clock) disable iff (!reset)
    (in_valid_1 && issue_pkg::is_csr_op(in_op_1)) |->
    in_csr_1 inside {issue_pkg::csr_fs, issue_pkg::csr_frm, issue_pkg::csr_scratch});

endmodule

`default_nettype wire

// ==== design/issue_csr.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_csr (
  input  logic clock,
  input  logic reset,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [issue_pkg::apb_addr_width-1:0] paddr,
  input  logic [issue_pkg::data_width-1:0] pwdata,
  output logic [issue_pkg::data_width-1:0] prdata,
  output logic pready,
  output logic pslverr,
  input  issue_pkg::csr_addr_t csr_rd_addr,
  output logic [issue_pkg::data_width-1:0] csr_rd_data,
  input  logic csr_wr_en,
  input  issue_pkg::csr_addr_t csr_wr_addr,
  input  logic [issue_pkg::data_width-1:0] csr_wr_data,
  output logic fp_enable,
  output logic [issue_pkg::rm_width-1:0] frm
);

  logic [issue_pkg::fs_width-1:0] fs_q;
  logic [issue_pkg::rm_width-1:0] frm_q;
  logic [issue_pkg::data_width-1:0] scratch_q;
  issue_pkg::csr_addr_t apb_csr;
  logic apb_mapped;
  logic apb_write;

  assign apb_csr = issue_pkg::csr_addr_t'(paddr[issue_pkg::apb_addr_width-1:2]);
  assign apb_mapped = paddr[1:0] == 2'b00 &&
                      apb_csr inside {issue_pkg::csr_fs, issue_pkg::csr_frm,
                                      issue_pkg::csr_scratch};
  assign apb_write = psel && penable && pwrite && apb_mapped;

  // Pipeline write port has priority over APB
  always_ff @(posedge clock) begin
    if (!reset) begin
      fs_q <= '0;
      frm_q <= '0;
      scratch_q <= '0;
    end else begin
      if (csr_wr_en && csr_wr_addr == issue_pkg::csr_fs) begin
        fs_q <= csr_wr_data[issue_pkg::fs_width-1:0];
      end else if (apb_write && apb_csr == issue_pkg::csr_fs) begin
        fs_q <= pwdata[issue_pkg::fs_width-1:0];
      end
      if (csr_wr_en && csr_wr_addr == issue_pkg::csr_frm) begin
        frm_q <= csr_wr_data[issue_pkg::rm_width-1:0];
      end else if (apb_write && apb_csr == issue_pkg::csr_frm) begin
        frm_q <= pwdata[issue_pkg::rm_width-1:0];
      end
      if (csr_wr_en && csr_wr_addr == issue_pkg::csr_scratch) begin
        scratch_q <= csr_wr_data;
      end else if (apb_write && apb_csr == issue_pkg::csr_scratch) begin
        scratch_q <= pwdata;
      end
    end
  end

  function automatic logic [issue_pkg::data_width-1:0] csr_value(
    issue_pkg::csr_addr_t sel,
    logic [issue_pkg::fs_width-1:0] fs,
    logic [issue_pkg::rm_width-1:0] rm,
    logic [issue_pkg::data_width-1:0] scratch
  );
    case (sel)
      issue_pkg::csr_fs:      return issue_pkg::data_width'(fs);
      issue_pkg::csr_frm:     return issue_pkg::data_width'(rm);
      issue_pkg::csr_scratch: return scratch;
      default:                return '0;
    endcase
  endfunction

  assign prdata = (psel && !pwrite && apb_mapped) ?
                  csr_value(apb_csr, fs_q, frm_q, scratch_q) : '0;
  assign pready = 1'b1;
  assign pslverr = psel && penable && !apb_mapped;

  assign csr_rd_data = csr_value(csr_rd_addr, fs_q, frm_q, scratch_q);
  assign fp_enable = fs_q[0];
  assign frm = frm_q;

  assert property (@(posedge clock) disable iff (!reset) penable |-> psel);

endmodule

`default_nettype wire

// ==== design/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

  localparam int reg_addr_width = 5;
  localparam int reg_count = 1 << reg_addr_width;
  localparam int data_width = 32;
  localparam int rm_width = 3;
  localparam int fs_width = 1;
  localparam int apb_addr_width = 4;

  // Rounding field value that defers to the CSR frm
  localparam logic [rm_width-1:0] rm_dynamic = 3'b111;

  typedef enum logic [2:0] {
    op_nop,
    op_alu,
    op_load,
    op_store,
    op_fpu,
    op_csr_read,
    op_csr_write,
    op_illegal
  } opcode_t;

  // Index equals APB byte address divided by four
  typedef enum logic [1:0] {
    csr_fs,
    csr_frm,
    csr_scratch
  } csr_addr_t;

  function automatic logic reads_rs1(opcode_t op);
    return op inside {op_alu, op_load, op_store, op_fpu, op_csr_write};
  endfunction

  function automatic logic reads_rs2(opcode_t op);
    return op inside {op_alu, op_store};
  endfunction

  function automatic logic is_csr_op(opcode_t op);
    return op inside {op_csr_read, op_csr_write};
  endfunction

  function automatic logic is_mem_op(opcode_t op);
    return op inside {op_load, op_store};
  endfunction

  // True when op reads register r through either source field
  function automatic logic reads_reg(
    opcode_t op,
    logic [reg_addr_width-1:0] rs1,
    logic [reg_addr_width-1:0] rs2,
    logic [reg_addr_width-1:0] r
  );
    return (reads_rs1(op) && rs1 == r) || (reads_rs2(op) && rs2 == r);
  endfunction

endpackage

`default_nettype wire

// ==== design/issue_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_top (
  input  logic clock,
  input  logic reset,
  input  logic in_valid_0,
  input  issue_pkg::opcode_t in_op_0,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rd_0,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rs1_0,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rs2_0,
  input  logic [issue_pkg::rm_width-1:0] in_rm_0,
  input  issue_pkg::csr_addr_t in_csr_0,
  input  logic in_valid_1,
  input  issue_pkg::opcode_t in_op_1,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rd_1,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rs1_1,
  input  logic [issue_pkg::reg_addr_width-1:0] in_rs2_1,
  input  logic [issue_pkg::rm_width-1:0] in_rm_1,
  input  issue_pkg::csr_addr_t in_csr_1,
  output logic [1:0] take_count,
  output logic stall,
  input  logic ex_load,
  input  logic [issue_pkg::reg_addr_width-1:0] ex_rd,
  input  logic ex_stall,
  input  logic flush,
  input  logic wb_en_0,
  input  logic [issue_pkg::reg_addr_width-1:0] wb_rd_0,
  input  logic [issue_pkg::data_width-1:0] wb_data_0,
  input  logic wb_en_1,
  input  logic [issue_pkg::reg_addr_width-1:0] wb_rd_1,
  input  logic [issue_pkg::data_width-1:0] wb_data_1,
  output logic out_valid_0,
  output issue_pkg::opcode_t out_op_0,
  output logic [issue_pkg::reg_addr_width-1:0] out_rd_0,
  output logic [issue_pkg::data_width-1:0] out_src1_0,
  output logic [issue_pkg::data_width-1:0] out_src2_0,
  output logic [issue_pkg::rm_width-1:0] out_rm_0,
  output logic out_valid_1,
  output issue_pkg::opcode_t out_op_1,
  output logic [issue_pkg::reg_addr_width-1:0] out_rd_1,
  output logic [issue_pkg::data_width-1:0] out_src1_1,
  output logic [issue_pkg::data_width-1:0] out_src2_1,
  output logic [issue_pkg::rm_width-1:0] out_rm_1,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [issue_pkg::apb_addr_width-1:0] paddr,
  input  logic [issue_pkg::data_width-1:0] pwdata,
  output logic [issue_pkg::data_width-1:0] prdata,
  output logic pready,
  output logic pslverr
);

  logic pair_ok;
  logic [issue_pkg::reg_addr_width-1:0] raddr0;
  logic [issue_pkg::reg_addr_width-1:0] raddr1;
  logic [issue_pkg::reg_addr_width-1:0] raddr2;
  logic [issue_pkg::reg_addr_width-1:0] raddr3;
  logic [issue_pkg::data_width-1:0] rdata0;
  logic [issue_pkg::data_width-1:0] rdata1;
  logic [issue_pkg::data_width-1:0] rdata2;
  logic [issue_pkg::data_width-1:0] rdata3;
  issue_pkg::csr_addr_t csr_rd_addr;
  logic [issue_pkg::data_width-1:0] csr_rd_data;
  logic fp_enable;
  logic [issue_pkg::rm_width-1:0] frm;
  logic csr_wr_en;
  issue_pkg::csr_addr_t csr_wr_addr;
  logic [issue_pkg::data_width-1:0] csr_wr_data;

  pair_check u_pair (
    .op0     (in_op_0),
    .rd0     (in_rd_0),
    .op1     (in_op_1),
    .rs1_1   (in_rs1_1),
    .rs2_1   (in_rs2_1),
    .pair_ok (pair_ok)
  );

  register_read u_regs (
    .clock    (clock),
    .reset    (reset),
    .raddr0   (raddr0),
    .raddr1   (raddr1),
    .raddr2   (raddr2),
    .raddr3   (raddr3),
    .rdata0   (rdata0),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .rdata3   (rdata3),
    .wb_en0   (wb_en_0),
    .wb_rd0   (wb_rd_0),
    .wb_data0 (wb_data_0),
    .wb_en1   (wb_en_1),
    .wb_rd1   (wb_rd_1),
    .wb_data1 (wb_data_1)
  );

  // Port names match the signals of this level one to one
  issue_csr u_csr (.*);

  issue_control u_control (.*);

endmodule

`default_nettype wire

// ==== design/pair_check.sv ====
`timescale 1ns/1ns
`default_nettype none

module pair_check (
  input  issue_pkg::opcode_t op0,
  input  logic [issue_pkg::reg_addr_width-1:0] rd0,
  input  issue_pkg::opcode_t op1,
  input  logic [issue_pkg::reg_addr_width-1:0] rs1_1,
  input  logic [issue_pkg::reg_addr_width-1:0] rs2_1,
  output logic pair_ok
);

  logic raw_dep;
  logic mem_conflict;
  logic csr_conflict;

  // Slot 1 depends on the result of slot 0
  assign raw_dep = rd0 != '0 && issue_pkg::reads_reg(op1, rs1_1, rs2_1, rd0);

  // Only one memory port
  assign mem_conflict = issue_pkg::is_mem_op(op0) && issue_pkg::is_mem_op(op1);

  // CSR ops always go alone through slot 0
  assign csr_conflict = issue_pkg::is_csr_op(op0) || issue_pkg::is_csr_op(op1);

  assign pair_ok = !(raw_dep || mem_conflict || csr_conflict);

endmodule

`default_nettype wire

// ==== design/register_read.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_read (
  input  logic clock,
  input  logic reset,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr0,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr1,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr2,
  input  logic [issue_pkg::reg_addr_width-1:0] raddr3,
  output logic [issue_pkg::data_width-1:0] rdata0,
  output logic [issue_pkg::data_width-1:0] rdata1,
  output logic [issue_pkg::data_width-1:0] rdata2,
  output logic [issue_pkg::data_width-1:0] rdata3,
  input  logic wb_en0,
  input  logic [issue_pkg::reg_addr_width-1:0] wb_rd0,
  input  logic [issue_pkg::data_width-1:0] wb_data0,
  input  logic wb_en1,
  input  logic [issue_pkg::reg_addr_width-1:0] wb_rd1,
  input  logic [issue_pkg::data_width-1:0] wb_data1
);

  logic [issue_pkg::data_width-1:0] regs [issue_pkg::reg_count];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < issue_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // x0 is never written and stays zero
      if (wb_en0 && wb_rd0 != '0) begin
        regs[wb_rd0] <= wb_data0;
      end
      // Port 1 is younger, so its write lands last
      if (wb_en1 && wb_rd1 != '0) begin
        regs[wb_rd1] <= wb_data1;
      end
    end
  end

  // Without bypass a same-cycle write shows up next cycle
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];
  assign rdata3 = regs[raddr3];

  // Writeback lanes must agree when both target x0
  assert property (@(posedge clock) disable iff (!reset)
    (wb_en0 && wb_en1 && wb_rd0 == '0 && wb_rd1 == '0) |-> wb_data0 == wb_data1);

endmodule

`default_nettype wire

// ==== sim/issue_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_tb;

  localparam int reset_len = 2;
  localparam int apb_len = 30;
  localparam int random_len = 200;
  localparam int load_use_len = 150;
  localparam int fp_len = 60;
  localparam int csr_len = 30;
  localparam int stall_len = 30;
  localparam int cycle_limit =
    (reset_len + apb_len + random_len + load_use_len + fp_len + csr_len + stall_len) * 3 / 2;

  typedef struct packed {
    logic [2:0] op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] rm;
    logic [1:0] csr;
  } instr_t;

  logic clock;
  logic reset;
  logic in_valid_0;
  issue_pkg::opcode_t in_op_0;
  logic [4:0] in_rd_0;
  logic [4:0] in_rs1_0;
  logic [4:0] in_rs2_0;
  logic [2:0] in_rm_0;
  issue_pkg::csr_addr_t in_csr_0;
  logic in_valid_1;
  issue_pkg::opcode_t in_op_1;
  logic [4:0] in_rd_1;
  logic [4:0] in_rs1_1;
  logic [4:0] in_rs2_1;
  logic [2:0] in_rm_1;
  issue_pkg::csr_addr_t in_csr_1;
  logic [1:0] take_count;
  logic stall;
  logic ex_load;
  logic [4:0] ex_rd;
  logic ex_stall;
  logic flush;
  logic wb_en_0;
  logic [4:0] wb_rd_0;
  logic [31:0] wb_data_0;
  logic wb_en_1;
  logic [4:0] wb_rd_1;
  logic [31:0] wb_data_1;
  logic out_valid_0;
  issue_pkg::opcode_t out_op_0;
  logic [4:0] out_rd_0;
  logic [31:0] out_src1_0;
  logic [31:0] out_src2_0;
  logic [2:0] out_rm_0;
  logic out_valid_1;
  issue_pkg::opcode_t out_op_1;
  logic [4:0] out_rd_1;
  logic [31:0] out_src1_1;
  logic [31:0] out_src2_1;
  logic [2:0] out_rm_1;
  logic psel;
  logic penable;
  logic pwrite;
  logic [3:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  // Reference model state
  logic [31:0] m_regs [32];
  logic m_fs;
  logic [2:0] m_frm;
  logic [31:0] m_scratch;
  logic m_pending;
  logic [1:0] m_wr_addr;
  logic [31:0] m_wr_data;
  logic m_valid [2];
  logic [2:0] m_op [2];
  logic [4:0] m_rd [2];
  logic [31:0] m_src1 [2];
  logic [31:0] m_src2 [2];
  logic [2:0] m_rm [2];
  instr_t fe_q [$];

  logic [31:0] lfsr_state;
  logic [31:0] apb_data;
  logic apb_err;
  int errors;
  int checks;
  int tests;
  int failed_tests;
  int cycles;
  int ser_count;

  issue_top DUT (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Simulation timed out after %0d cycles", cycles);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic uses_rs1(logic [2:0] op);
    return op == issue_pkg::op_alu || op == issue_pkg::op_load || op == issue_pkg::op_store ||
           op == issue_pkg::op_fpu || op == issue_pkg::op_csr_write;
  endfunction

  function automatic logic uses_rs2(logic [2:0] op);
    return op == issue_pkg::op_alu || op == issue_pkg::op_store;
  endfunction

  function automatic logic is_mem(logic [2:0] op);
    return op == issue_pkg::op_load || op == issue_pkg::op_store;
  endfunction

  function automatic logic is_csr(logic [2:0] op);
    return op == issue_pkg::op_csr_read || op == issue_pkg::op_csr_write;
  endfunction

  function automatic logic depends_on(instr_t i, logic [4:0] r);
    return (uses_rs1(i.op) && i.rs1 == r) || (uses_rs2(i.op) && i.rs2 == r);
  endfunction

  function automatic logic [31:0] csr_model(logic [1:0] sel);
    case (sel)
      2'd0:    return {31'b0, m_fs};
      2'd1:    return {29'b0, m_frm};
      2'd2:    return m_scratch;
      default: return '0;
    endcase
  endfunction

  function automatic instr_t random_instr(logic fp);
    instr_t i;
    logic [1:0] kind;
    kind = 2'(rand_bits(2));
    if (fp) begin
      i.op = issue_pkg::op_fpu;
    end else if (kind == 2'd1) begin
      i.op = issue_pkg::op_load;
    end else if (kind == 2'd2) begin
      i.op = issue_pkg::op_store;
    end else begin
      i.op = issue_pkg::op_alu;
    end
    // Small register range keeps hazards frequent
    i.rd = 5'(rand_bits(3));
    i.rs1 = 5'(rand_bits(3));
    i.rs2 = 5'(rand_bits(3));
    i.rm = 3'(rand_bits(3));
    if (fp && 1'(rand_bits(1))) begin
      i.rm = issue_pkg::rm_dynamic;
    end
    i.csr = 2'd0;
    return i;
  endfunction

  task automatic check(logic [31:0] actual, logic [31:0] expected, string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %0t: %s: got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  task automatic write_csr(logic [1:0] sel, logic [31:0] data);
    case (sel)
      2'd0:    m_fs = data[0];
      2'd1:    m_frm = data[2:0];
      2'd2:    m_scratch = data;
      default: ;
    endcase
  endtask

  task automatic issue_slot(int s, instr_t i);
    m_op[s] = (i.op == issue_pkg::op_fpu && !m_fs) ? 3'(issue_pkg::op_illegal) : i.op;
    m_rd[s] = i.rd;
    m_rm[s] = (i.rm == issue_pkg::rm_dynamic) ? m_frm : i.rm;
    if (s == 0 && i.op == issue_pkg::op_csr_read) begin
      m_src1[s] = csr_model(i.csr);
    end else begin
      m_src1[s] = uses_rs1(i.op) ? m_regs[i.rs1] : 32'd0;
    end
    m_src2[s] = uses_rs2(i.op) ? m_regs[i.rs2] : 32'd0;
  endtask

  task automatic present();
    instr_t i0;
    instr_t i1;
    i0 = fe_q.size() > 0 ? fe_q[0] : '0;
    i1 = fe_q.size() > 1 ? fe_q[1] : '0;
    in_valid_0 = fe_q.size() > 0;
    in_op_0 = issue_pkg::opcode_t'(i0.op);
    in_rd_0 = i0.rd;
    in_rs1_0 = i0.rs1;
    in_rs2_0 = i0.rs2;
    in_rm_0 = i0.rm;
    in_csr_0 = issue_pkg::csr_addr_t'(i0.csr);
    in_valid_1 = fe_q.size() > 1;
    in_op_1 = issue_pkg::opcode_t'(i1.op);
    in_rd_1 = i1.rd;
    in_rs1_1 = i1.rs1;
    in_rs2_1 = i1.rs2;
    in_rm_1 = i1.rm;
    in_csr_1 = issue_pkg::csr_addr_t'(i1.csr);
  endtask

  task automatic compare_outputs();
    check(out_valid_0, m_valid[0], "slot 0 valid");
    check(out_valid_1, m_valid[1], "slot 1 valid");
    if (m_valid[0]) begin
      check(out_op_0, m_op[0], "slot 0 opcode");
      check(out_rd_0, m_rd[0], "slot 0 rd");
      check(out_src1_0, m_src1[0], "slot 0 src1");
      check(out_src2_0, m_src2[0], "slot 0 src2");
      check(out_rm_0, m_rm[0], "slot 0 rm");
    end
    if (m_valid[1]) begin
      check(out_op_1, m_op[1], "slot 1 opcode");
      check(out_rd_1, m_rd[1], "slot 1 rd");
      check(out_src1_1, m_src1[1], "slot 1 src1");
      check(out_src2_1, m_src2[1], "slot 1 src2");
      check(out_rm_1, m_rm[1], "slot 1 rm");
    end
  endtask

  // Present slots, check combinational outputs, then registered ones
  task automatic clock_cycle();
    instr_t i0;
    instr_t i1;
    logic v0;
    logic v1;
    logic h0;
    logic h1;
    logic ser;
    logic pair;
    logic mapped;
    logic apb_wr;
    logic [1:0] acsr;
    logic [1:0] take;
    present();
    @(negedge clock);
    v0 = fe_q.size() > 0;
    v1 = fe_q.size() > 1;
    i0 = v0 ? fe_q[0] : '0;
    i1 = v1 ? fe_q[1] : '0;
    h0 = ex_load && ex_rd != 5'd0 && depends_on(i0, ex_rd);
    h1 = ex_load && ex_rd != 5'd0 && depends_on(i1, ex_rd);
    ser = m_pending && (is_csr(i0.op) || i0.op == issue_pkg::op_fpu);
    pair = !((i0.rd != 5'd0 && depends_on(i1, i0.rd)) || (is_mem(i0.op) && is_mem(i1.op)) ||
             is_csr(i0.op) || is_csr(i1.op));
    if (ex_stall || flush || h0 || ser || !v0) begin
      take = 2'd0;
    end else if (v1 && pair && !h1) begin
      take = 2'd2;
    end else begin
      take = 2'd1;
    end
    // Cycles in which the DUT holds back a CSR op in slot 0
    if (v0 && is_csr(i0.op) && stall) begin
      ser_count++;
    end
    check(take_count, take, "take_count");
    check(stall, v0 && take == 2'd0, "stall");
    acsr = paddr[3:2];
    mapped = paddr[1:0] == 2'b00 && acsr != 2'd3;
    if (psel && penable) begin
      check(pready, 1'b1, "APB pready");
      check(pslverr, !mapped, "APB pslverr");
      check(prdata, (!pwrite && mapped) ? csr_model(acsr) : 32'd0, "APB read data");
      apb_data = prdata;
      apb_err = pslverr;
    end
    apb_wr = psel && penable && pwrite && mapped;
    if (flush) begin
      m_valid[0] = 1'b0;
      m_valid[1] = 1'b0;
    end else if (!ex_stall) begin
      m_valid[0] = take != 2'd0;
      m_valid[1] = take == 2'd2;
      issue_slot(0, i0);
      issue_slot(1, i1);
    end
    // Pipeline CSR write beats APB on the same CSR
    if (m_pending) begin
      write_csr(m_wr_addr, m_wr_data);
    end
    if (apb_wr && !(m_pending && m_wr_addr == acsr)) begin
      write_csr(acsr, pwdata);
    end
    m_pending = take != 2'd0 && i0.op == issue_pkg::op_csr_write;
    if (m_pending) begin
      m_wr_addr = i0.csr;
      m_wr_data = m_src1[0];
    end
    if (wb_en_0 && wb_rd_0 != 5'd0) begin
      m_regs[wb_rd_0] = wb_data_0;
    end
    if (wb_en_1 && wb_rd_1 != 5'd0) begin
      m_regs[wb_rd_1] = wb_data_1;
    end
    @(posedge clock);
    #1;
    repeat (take) begin
      void'(fe_q.pop_front());
    end
    compare_outputs();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (fe_q.size() > 0 && n < 20) begin
      clock_cycle();
      n++;
    end
    if (fe_q.size() > 0) begin
      errors++;
      $display("Front end still holds %0d instructions after 20 cycles", fe_q.size());
    end
  endtask

  task automatic apb_access(logic wr, logic [3:0] addr, logic [31:0] wdata);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    clock_cycle();
    penable = 1'b1;
    clock_cycle();
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic random_run(int n, logic with_load);
    for (int c = 0; c < n - 20; c++) begin
      while (fe_q.size() < 4) begin
        fe_q.push_back(random_instr(1'b0));
      end
      wb_en_0 = 1'(rand_bits(1));
      wb_rd_0 = 5'(rand_bits(3));
      wb_data_0 = rand_bits(32);
      wb_en_1 = 1'(rand_bits(1));
      wb_rd_1 = 5'(rand_bits(3));
      wb_data_1 = rand_bits(32);
      if (wb_en_0 && wb_en_1 && wb_rd_0 == 5'd0 && wb_rd_1 == 5'd0) begin
        wb_data_1 = wb_data_0;
      end
      ex_load = with_load ? 1'(rand_bits(1)) : 1'b0;
      ex_rd = 5'(rand_bits(3));
      clock_cycle();
    end
    wb_en_0 = 1'b0;
    wb_en_1 = 1'b0;
    ex_load = 1'b0;
    drain();
  endtask

  task automatic finish_test(string name, int start_errors);
    tests++;
    if (errors != start_errors) begin
      failed_tests++;
    end
    $display("%s: %0d errors", name, errors - start_errors);
  endtask

  task automatic test_apb();
    apb_access(1'b1, 4'h0, 32'hffff_ffff);
    apb_access(1'b0, 4'h0, 32'd0);
    check(apb_data, 32'h1, "fs read back masked");
    apb_access(1'b1, 4'h4, 32'hffff_fffd);
    apb_access(1'b0, 4'h4, 32'd0);
    check(apb_data, 32'h5, "frm read back masked");
    apb_access(1'b1, 4'h8, 32'h1234_abcd);
    apb_access(1'b0, 4'h8, 32'd0);
    check(apb_data, 32'h1234_abcd, "scratch read back");
    apb_access(1'b1, 4'hc, 32'hdead_beef);
    check(apb_err, 1'b1, "unmapped write raises pslverr");
    apb_access(1'b0, 4'hc, 32'd0);
    check(apb_err, 1'b1, "unmapped read raises pslverr");
  endtask

  task automatic test_fp();
    apb_access(1'b1, 4'h0, 32'd0);
    repeat (6) fe_q.push_back(random_instr(1'b1));
    drain();
    apb_access(1'b1, 4'h0, 32'd1);
    apb_access(1'b1, 4'h4, 32'd3);
    repeat (8) fe_q.push_back(random_instr(1'b1));
    drain();
  endtask

  task automatic test_csr();
    instr_t w;
    instr_t r;
    int start;
    start = ser_count;
    // Source registers get values unlike the current CSR contents
    wb_en_0 = 1'b1;
    wb_rd_0 = 5'd3;
    wb_data_0 = 32'h0000_0006;
    wb_en_1 = 1'b1;
    wb_rd_1 = 5'd5;
    wb_data_1 = 32'hc3c3_5a5a;
    clock_cycle();
    wb_en_0 = 1'b0;
    wb_en_1 = 1'b0;
    w = '0;
    w.op = issue_pkg::op_csr_write;
    w.rs1 = 5'd3;
    w.csr = issue_pkg::csr_frm;
    r = '0;
    r.op = issue_pkg::op_csr_read;
    r.rd = 5'd4;
    r.csr = issue_pkg::csr_frm;
    fe_q.push_back(w);
    fe_q.push_back(r);
    apb_access(1'b0, 4'h0, 32'd0);
    drain();
    // Commit lands on the same edge as an APB write to scratch
    w.rs1 = 5'd5;
    w.csr = issue_pkg::csr_scratch;
    r.csr = issue_pkg::csr_scratch;
    fe_q.push_back(w);
    fe_q.push_back(r);
    apb_access(1'b1, 4'h8, 32'h5555_aaaa);
    drain();
    check(ser_count - start, 2, "csr read held one cycle after each write");
  endtask

  task automatic test_stall();
    logic [31:0] snap_src1;
    logic snap_valid;
    repeat (6) fe_q.push_back(random_instr(1'b0));
    clock_cycle();
    clock_cycle();
    snap_src1 = m_src1[0];
    snap_valid = m_valid[0];
    ex_stall = 1'b1;
    repeat (3) clock_cycle();
    check(out_valid_0, snap_valid, "valid held under ex_stall");
    check(out_src1_0, snap_src1, "src1 held under ex_stall");
    ex_stall = 1'b0;
    flush = 1'b1;
    clock_cycle();
    check(out_valid_0, 1'b0, "flush clears slot 0");
    check(out_valid_1, 1'b0, "flush clears slot 1");
    flush = 1'b0;
    drain();
  endtask

  initial begin
    int start;
    lfsr_state = 32'hda3b_eacc;
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    ser_count = 0;
    reset = 1'b0;
    ex_load = 1'b0;
    ex_rd = '0;
    ex_stall = 1'b0;
    flush = 1'b0;
    wb_en_0 = 1'b0;
    wb_rd_0 = '0;
    wb_data_0 = '0;
    wb_en_1 = 1'b0;
    wb_rd_1 = '0;
    wb_data_1 = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    apb_data = '0;
    apb_err = 1'b0;
    present();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_fs = 1'b0;
    m_frm = '0;
    m_scratch = '0;
    m_pending = 1'b0;
    m_valid[0] = 1'b0;
    m_valid[1] = 1'b0;
    repeat (reset_len) @(posedge clock);
    #1;
    reset = 1'b1;
    check(out_valid_0, 1'b0, "slot 0 valid after reset");
    check(out_valid_1, 1'b0, "slot 1 valid after reset");
    check(prdata, 32'd0, "prdata after reset");

    start = errors;
    test_apb();
    finish_test("apb csr access", start);
    start = errors;
    random_run(random_len, 1'b0);
    finish_test("random alu/load/store", start);
    start = errors;
    random_run(load_use_len, 1'b1);
    finish_test("load-use hazards", start);
    start = errors;
    test_fp();
    finish_test("fp gate and rounding", start);
    start = errors;
    test_csr();
    finish_test("csr write serialization", start);
    start = errors;
    test_stall();
    finish_test("ex_stall and flush", start);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/issue_pkg.sv
design/pair_check.sv
design/register_read.sv
design/issue_csr.sv
design/issue_control.sv
design/issue_top.sv
sim/issue_tb.sv
